// ==== Makefile ====
# Verilator flow for the rubik CSB register file

VERILATOR ?= verilator
TOP       ?= tb_rbk_regfile
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# build, run, then search the output for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	  printf '%s\n' "$$out"; \
	  printf '%s\n' "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/rbk_csb_decode.sv ====
`timescale 1ns/1ps
module rbk_csb_decode (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  logic                     req_pvld,
  input  rbk_reg_pkg::req_pd_t     req_pd,
  output rbk_reg_pkg::reg_offset_t reg_offset,
  output rbk_reg_pkg::reg_data_t   reg_wr_data,
  output logic                     reg_wr_en,
  output logic                     reg_rd_en,
  output logic                     nposted_wr
);
  import rbk_reg_pkg::*;

  logic    req_pvld_q;
  req_pd_t req_pd_q;
  logic    req_write;
  logic    req_nposted;

  //////////////////////////////////////////////////////////////////////
  // request capture
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld_q <= 1'b0;
    end else begin
      req_pvld_q <= req_pvld; // one-cycle strobe, always ready
    end
  end

  // packet only loads with the strobe
  always_ff @(posedge nvdla_core_clk) begin
    if (req_pvld) begin
      req_pd_q <= req_pd;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // unpack
  //////////////////////////////////////////////////////////////////////
  assign reg_wr_data = req_pd_q[req_wdat_lsb +: reg_data_w];
  assign req_write   = req_pd_q[req_write_bit];
  assign req_nposted = req_pd_q[req_nposted_bit];

  // word address to byte offset, upper address bits dropped
  assign reg_offset = {req_pd_q[req_addr_lsb +: reg_offset_w-2], 2'b00};

  assign reg_wr_en  = req_pvld_q & req_write;
  assign reg_rd_en  = req_pvld_q & ~req_write;
  assign nposted_wr = reg_wr_en & req_nposted; // write that wants a response

endmodule

// ==== design/rbk_csb_resp.sv ====
`timescale 1ns/1ps
module rbk_csb_resp (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   reg_rd_en,
  input  logic                   nposted_wr,
  input  logic                   select_s,
  input  logic                   select_d0,
  input  logic                   select_d1,
  input  rbk_reg_pkg::reg_data_t s_rd_data,
  input  rbk_reg_pkg::reg_data_t d0_rd_data,
  input  rbk_reg_pkg::reg_data_t d1_rd_data,
  output logic                   resp_valid,
  output rbk_reg_pkg::resp_pd_t  resp_pd
);
  import rbk_reg_pkg::*;

  reg_data_t rd_data;
  resp_pd_t  rresp_pd;
  resp_pd_t  wresp_pd;

  // selects are one-hot
  assign rd_data = ({reg_data_w{select_s}}  & s_rd_data)
                 | ({reg_data_w{select_d0}} & d0_rd_data)
                 | ({reg_data_w{select_d1}} & d1_rd_data);

  //////////////////////////////////////////////////////////////////////
  // packet forming, error bit never set
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    rresp_pd                 = '0;
    rresp_pd[reg_data_w-1:0] = rd_data;
    rresp_pd[resp_kind_bit]  = 1'b0; // read
    wresp_pd                 = '0;
    wresp_pd[resp_kind_bit]  = 1'b1; // write ack carries no data
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_valid <= 1'b0;
      resp_pd    <= '0;
    end else begin
      resp_valid <= reg_rd_en | nposted_wr; // posted writes stay silent
      if (reg_rd_en) begin
        resp_pd <= rresp_pd;
      end else if (nposted_wr) begin
        resp_pd <= wresp_pd;
      end
    end
  end

endmodule

// ==== design/rbk_dual_reg.sv ====
`timescale 1ns/1ps
module rbk_dual_reg (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  rbk_reg_pkg::reg_offset_t reg_offset,
  input  rbk_reg_pkg::reg_data_t   reg_wr_data,
  input  logic                     reg_wr_en,      // already gated by select and op_en
  input  logic                     op_en,          // this group's op enable, readback only
  output rbk_reg_pkg::reg_data_t   reg_rd_data,
  output logic                     op_en_trigger,
  output rbk_reg_pkg::mode_t       rubik_mode,
  output rbk_reg_pkg::prec_t       in_precision,
  output rbk_reg_pkg::dim_t        datain_width,
  output rbk_reg_pkg::dim_t        datain_height,
  output rbk_reg_pkg::addr_low_t   dain_addr_low,
  output rbk_reg_pkg::addr_low_t   dain_line_stride,
  output logic                     perf_en
);
  import rbk_reg_pkg::*;

  logic wr_misc;
  logic wr_size;
  logic wr_addr_low;
  logic wr_line_stride;
  logic wr_perf;

  //////////////////////////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////////////////////////
  assign op_en_trigger  = reg_wr_en & (reg_offset == offset_op_enable); // op_en lives in ctrl
  assign wr_misc        = reg_wr_en & (reg_offset == offset_misc_cfg);
  assign wr_size        = reg_wr_en & (reg_offset == offset_datain_size);
  assign wr_addr_low    = reg_wr_en & (reg_offset == offset_dain_addr_low);
  assign wr_line_stride = reg_wr_en & (reg_offset == offset_dain_line_stride);
  assign wr_perf        = reg_wr_en & (reg_offset == offset_perf_enable);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      rubik_mode       <= '0;
      in_precision     <= '0;
      datain_width     <= '0;
      datain_height    <= '0;
      dain_addr_low    <= '0;
      dain_line_stride <= '0;
      perf_en          <= 1'b0;
    end else begin
      if (wr_misc) begin
        rubik_mode   <= reg_wr_data[mode_w-1:0];
        in_precision <= reg_wr_data[misc_prec_lsb +: prec_w];
      end
      if (wr_size) begin
        datain_width  <= reg_wr_data[dim_w-1:0];
        datain_height <= reg_wr_data[size_height_lsb +: dim_w];
      end
      if (wr_addr_low)    dain_addr_low    <= reg_wr_data[addr_low_w-1:0];
      if (wr_line_stride) dain_line_stride <= reg_wr_data[addr_low_w-1:0];
      if (wr_perf)        perf_en          <= reg_wr_data[0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback, unmapped reads zero
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    reg_rd_data = '0;
    case (reg_offset)
      offset_op_enable: reg_rd_data[0] = op_en;
      offset_misc_cfg: begin
        reg_rd_data[mode_w-1:0]              = rubik_mode;
        reg_rd_data[misc_prec_lsb +: prec_w] = in_precision;
      end
      offset_datain_size: begin
        reg_rd_data[dim_w-1:0]                = datain_width;
        reg_rd_data[size_height_lsb +: dim_w] = datain_height;
      end
      offset_dain_addr_low:    reg_rd_data[addr_low_w-1:0] = dain_addr_low;
      offset_dain_line_stride: reg_rd_data[addr_low_w-1:0] = dain_line_stride;
      offset_perf_enable:      reg_rd_data[0] = perf_en;
      default: ;
    endcase
  end

endmodule

// ==== design/rbk_group_ctrl.sv ====
`timescale 1ns/1ps
module rbk_group_ctrl #(
  parameter int OP_EN_DELAY = rbk_reg_pkg::op_en_delay
) (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  rbk_reg_pkg::reg_offset_t reg_offset,
  input  rbk_reg_pkg::reg_data_t   reg_wr_data,
  input  logic                     reg_wr_en,
  input  logic                     done,
  input  logic                     d0_op_en_trigger,
  input  logic                     d1_op_en_trigger,
  input  rbk_reg_pkg::mode_t       d0_rubik_mode,
  input  rbk_reg_pkg::prec_t       d0_in_precision,
  input  rbk_reg_pkg::dim_t        d0_datain_width,
  input  rbk_reg_pkg::dim_t        d0_datain_height,
  input  rbk_reg_pkg::addr_low_t   d0_dain_addr_low,
  input  rbk_reg_pkg::addr_low_t   d0_dain_line_stride,
  input  logic                     d0_perf_en,
  input  rbk_reg_pkg::mode_t       d1_rubik_mode,
  input  rbk_reg_pkg::prec_t       d1_in_precision,
  input  rbk_reg_pkg::dim_t        d1_datain_width,
  input  rbk_reg_pkg::dim_t        d1_datain_height,
  input  rbk_reg_pkg::addr_low_t   d1_dain_addr_low,
  input  rbk_reg_pkg::addr_low_t   d1_dain_line_stride,
  input  logic                     d1_perf_en,
  output logic                     d0_wr_en,
  output logic                     d1_wr_en,
  output logic                     select_s,
  output logic                     select_d0,
  output logic                     select_d1,
  output logic                     d0_op_en,
  output logic                     d1_op_en,
  output rbk_reg_pkg::reg_data_t   s_rd_data,
  output rbk_reg_pkg::mode_t       rubik_mode,
  output rbk_reg_pkg::prec_t       in_precision,
  output rbk_reg_pkg::dim_t        datain_width,
  output rbk_reg_pkg::dim_t        datain_height,
  output rbk_reg_pkg::addr_low_t   dain_addr_low,
  output rbk_reg_pkg::addr_low_t   dain_line_stride,
  output logic                     perf_en,
  output logic                     op_en
);
  import rbk_reg_pkg::*;

  logic                   producer;
  logic                   consumer;
  status_t                status_0;
  status_t                status_1;
  logic                   op_en_ori;
  logic [OP_EN_DELAY-1:0] op_en_dly;

  //////////////////////////////////////////////////////////////////////
  // group select, writes blocked while the group is armed
  //////////////////////////////////////////////////////////////////////
  assign select_s  = (reg_offset < dual_base);
  assign select_d0 = ~select_s & ~producer;
  assign select_d1 = ~select_s & producer;
  assign d0_wr_en  = reg_wr_en & select_d0 & ~d0_op_en;
  assign d1_wr_en  = reg_wr_en & select_d1 & ~d1_op_en;

  //////////////////////////////////////////////////////////////////////
  // pointers and op enables
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
      consumer <= 1'b0;
      d0_op_en <= 1'b0;
      d1_op_en <= 1'b0;
    end else begin
      if (reg_wr_en & select_s & (reg_offset == offset_pointer)) begin
        producer <= reg_wr_data[0]; // consumer bit is read only
      end
      if (done) consumer <= ~consumer;
      // set only from clear, done clears the consumer's group
      if (~d0_op_en & d0_op_en_trigger) d0_op_en <= reg_wr_data[0];
      else if (done & ~consumer)        d0_op_en <= 1'b0;
      if (~d1_op_en & d1_op_en_trigger) d1_op_en <= reg_wr_data[0];
      else if (done & consumer)         d1_op_en <= 1'b0;
    end
  end

  // running when the consumer points at the group
  assign status_0 = ~d0_op_en ? status_idle : (~consumer ? status_running : status_pending);
  assign status_1 = ~d1_op_en ? status_idle : (consumer ? status_running : status_pending);

  always_comb begin
    s_rd_data = '0;
    case (reg_offset)
      offset_pointer: begin
        s_rd_data[0]                = producer;
        s_rd_data[ptr_consumer_bit] = consumer;
      end
      offset_status: begin
        s_rd_data[1:0]                = status_0;
        s_rd_data[status_1_lsb +: 2] = status_1;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // consumer side outputs
  //////////////////////////////////////////////////////////////////////
  assign rubik_mode       = consumer ? d1_rubik_mode       : d0_rubik_mode;
  assign in_precision     = consumer ? d1_in_precision     : d0_in_precision;
  assign datain_width     = consumer ? d1_datain_width     : d0_datain_width;
  assign datain_height    = consumer ? d1_datain_height    : d0_datain_height;
  assign dain_addr_low    = consumer ? d1_dain_addr_low    : d0_dain_addr_low;
  assign dain_line_stride = consumer ? d1_dain_line_stride : d0_dain_line_stride;
  assign perf_en          = consumer ? d1_perf_en          : d0_perf_en;
  assign op_en_ori        = consumer ? d1_op_en            : d0_op_en;

  // op_en delay line, flushed by done
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_dly <= '0;
    end else if (done) begin
      op_en_dly <= '0;
    end else begin
      op_en_dly[0] <= op_en_ori;
      for (int i = 1; i < OP_EN_DELAY; i++) begin
        op_en_dly[i] <= op_en_dly[i-1];
      end
    end
  end

  assign op_en = op_en_dly[OP_EN_DELAY-1];

endmodule

// ==== design/rbk_reg_pkg.sv ====
package rbk_reg_pkg;

  // csb request packet, address is a word address
  localparam int req_pd_w        = 63;
  localparam int req_addr_lsb    = 0;
  localparam int req_wdat_lsb    = 22;
  localparam int req_write_bit   = 54;
  localparam int req_nposted_bit = 55;

  // response packet
  localparam int resp_pd_w      = 34;
  localparam int resp_error_bit = 32;
  localparam int resp_kind_bit  = 33; // 0 read, 1 write

  localparam int reg_offset_w = 12;   // 4KB space per unit
  localparam int reg_data_w   = 32;

  typedef logic [req_pd_w-1:0]     req_pd_t;
  typedef logic [resp_pd_w-1:0]    resp_pd_t;
  typedef logic [reg_offset_w-1:0] reg_offset_t;
  typedef logic [reg_data_w-1:0]   reg_data_t;

  // single group
  localparam reg_offset_t offset_pointer = 12'h000;
  localparam reg_offset_t offset_status  = 12'h004;
  localparam int ptr_consumer_bit = 16;
  localparam int status_1_lsb     = 16;

  localparam reg_offset_t dual_base = 12'h008; // first ping-pong offset

  // ping-pong groups
  localparam reg_offset_t offset_op_enable        = 12'h008;
  localparam reg_offset_t offset_misc_cfg         = 12'h00c;
  localparam reg_offset_t offset_datain_size      = 12'h010;
  localparam reg_offset_t offset_dain_addr_low    = 12'h014;
  localparam reg_offset_t offset_dain_line_stride = 12'h018;
  localparam reg_offset_t offset_perf_enable      = 12'h01c;
  localparam int misc_prec_lsb   = 8;
  localparam int size_height_lsb = 16;

  // field widths
  localparam int dim_w      = 13;
  localparam int addr_low_w = 27;
  localparam int mode_w     = 2;
  localparam int prec_w     = 2;

  typedef logic [dim_w-1:0]      dim_t;
  typedef logic [addr_low_w-1:0] addr_low_t;
  typedef logic [mode_w-1:0]     mode_t;
  typedef logic [prec_w-1:0]     prec_t;

  typedef enum logic [1:0] {
    status_idle    = 2'd0,
    status_pending = 2'd1,
    status_running = 2'd2
  } status_t;

  localparam int op_en_delay = 3; // default op_en latency in cycles

endpackage

// ==== design/rbk_regfile.sv ====
`timescale 1ns/1ps
module rbk_regfile #(
  parameter int OP_EN_DELAY = rbk_reg_pkg::op_en_delay
) (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   req_pvld,
  input  rbk_reg_pkg::req_pd_t   req_pd,
  input  logic                   done,
  output logic                   resp_valid,
  output rbk_reg_pkg::resp_pd_t  resp_pd,
  output logic                   op_en,
  output logic                   perf_en,
  output rbk_reg_pkg::mode_t     rubik_mode,
  output rbk_reg_pkg::prec_t     in_precision,
  output rbk_reg_pkg::dim_t      datain_width,
  output rbk_reg_pkg::dim_t      datain_height,
  output rbk_reg_pkg::addr_low_t dain_addr_low,
  output rbk_reg_pkg::addr_low_t dain_line_stride
);
  import rbk_reg_pkg::*;

  // request side
  reg_offset_t reg_offset;
  reg_data_t   reg_wr_data;
  logic        reg_wr_en;
  logic        reg_rd_en;
  logic        nposted_wr;
  // group control
  logic        select_s, select_d0, select_d1;
  logic        d0_wr_en, d1_wr_en;
  logic        d0_op_en, d1_op_en;
  logic        d0_op_en_trigger, d1_op_en_trigger;
  reg_data_t   s_rd_data, d0_rd_data, d1_rd_data;
  // per group fields
  mode_t       d0_rubik_mode, d1_rubik_mode;
  prec_t       d0_in_precision, d1_in_precision;
  dim_t        d0_datain_width, d1_datain_width;
  dim_t        d0_datain_height, d1_datain_height;
  addr_low_t   d0_dain_addr_low, d1_dain_addr_low;
  addr_low_t   d0_dain_line_stride, d1_dain_line_stride;
  logic        d0_perf_en, d1_perf_en;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////
  rbk_csb_decode u_csb_decode (
    .nvdla_core_clk, .nvdla_core_rstn, .req_pvld, .req_pd,
    .reg_offset, .reg_wr_data, .reg_wr_en, .reg_rd_en, .nposted_wr
  );

  //////////////////////////////////////////////////////////////////////
  // execute
  //////////////////////////////////////////////////////////////////////
  rbk_group_ctrl #(.OP_EN_DELAY(OP_EN_DELAY)) u_group_ctrl (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_offset, .reg_wr_data, .reg_wr_en, .done,
    .d0_op_en_trigger, .d1_op_en_trigger,
    .d0_rubik_mode, .d0_in_precision, .d0_datain_width, .d0_datain_height,
    .d0_dain_addr_low, .d0_dain_line_stride, .d0_perf_en,
    .d1_rubik_mode, .d1_in_precision, .d1_datain_width, .d1_datain_height,
    .d1_dain_addr_low, .d1_dain_line_stride, .d1_perf_en,
    .d0_wr_en, .d1_wr_en, .select_s, .select_d0, .select_d1,
    .d0_op_en, .d1_op_en, .s_rd_data,
    .rubik_mode, .in_precision, .datain_width, .datain_height,
    .dain_addr_low, .dain_line_stride, .perf_en, .op_en
  );

  rbk_dual_reg u_dual_reg_d0 (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_offset, .reg_wr_data,
    .reg_wr_en        (d0_wr_en),
    .op_en            (d0_op_en),
    .reg_rd_data      (d0_rd_data),
    .op_en_trigger    (d0_op_en_trigger),
    .rubik_mode       (d0_rubik_mode),
    .in_precision     (d0_in_precision),
    .datain_width     (d0_datain_width),
    .datain_height    (d0_datain_height),
    .dain_addr_low    (d0_dain_addr_low),
    .dain_line_stride (d0_dain_line_stride),
    .perf_en          (d0_perf_en)
  );

  rbk_dual_reg u_dual_reg_d1 (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_offset, .reg_wr_data,
    .reg_wr_en        (d1_wr_en),
    .op_en            (d1_op_en),
    .reg_rd_data      (d1_rd_data),
    .op_en_trigger    (d1_op_en_trigger),
    .rubik_mode       (d1_rubik_mode),
    .in_precision     (d1_in_precision),
    .datain_width     (d1_datain_width),
    .datain_height    (d1_datain_height),
    .dain_addr_low    (d1_dain_addr_low),
    .dain_line_stride (d1_dain_line_stride),
    .perf_en          (d1_perf_en)
  );

  //////////////////////////////////////////////////////////////////////
  // result
  //////////////////////////////////////////////////////////////////////
  rbk_csb_resp u_csb_resp (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_rd_en, .nposted_wr,
    .select_s, .select_d0, .select_d1,
    .s_rd_data, .d0_rd_data, .d1_rd_data,
    .resp_valid, .resp_pd
  );

endmodule

// ==== tb/rbk_checker.sv ====
`timescale 1ns/1ps
module rbk_checker (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   resp_valid,
  input  rbk_reg_pkg::resp_pd_t  resp_pd,
  input  logic                   op_en,
  input  logic                   perf_en,
  input  rbk_reg_pkg::mode_t     rubik_mode,
  input  rbk_reg_pkg::prec_t     in_precision,
  input  rbk_reg_pkg::dim_t      datain_width,
  input  rbk_reg_pkg::dim_t      datain_height,
  input  rbk_reg_pkg::addr_low_t dain_addr_low,
  input  rbk_reg_pkg::addr_low_t dain_line_stride,
  input  logic                   exp_push,      // request with a response in this cycle
  input  rbk_reg_pkg::resp_pd_t  exp_pd,
  input  logic                   out_chk,       // compare the field outputs this cycle
  input  logic                   exp_op_en,
  input  logic                   exp_perf_en,
  input  rbk_reg_pkg::mode_t     exp_mode,
  input  rbk_reg_pkg::prec_t     exp_prec,
  input  rbk_reg_pkg::dim_t      exp_width,
  input  rbk_reg_pkg::dim_t      exp_height,
  input  rbk_reg_pkg::addr_low_t exp_addr_low,
  input  rbk_reg_pkg::addr_low_t exp_stride,
  output int                     error_count,
  output int                     check_count,
  output int                     pending
);
  import rbk_reg_pkg::*;

  resp_pd_t exp_q [$];
  int       due_q [$];   // cycle in which each response must show up
  int       cycle;

  task automatic compare_val(input string name, input logic [33:0] exp_v,
                             input logic [33:0] got_v);
    check_count++;
    if (exp_v !== got_v) begin
      error_count++;
      $display("ERROR %0t %s expected %h got %h", $time, name, exp_v, got_v);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // response tracking, sampled on the rising edge
  //////////////////////////////////////////////////////////////////////
  always @(posedge nvdla_core_clk) begin
    if (!nvdla_core_rstn) begin
      cycle       = 0;
      error_count = 0;
      check_count = 0;
      exp_q.delete();
      due_q.delete();
    end else begin
      cycle++;
      if (exp_push) begin
        exp_q.push_back(exp_pd);
        due_q.push_back(cycle + 2); // request lands now, response two edges on
      end
      if (resp_valid) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("response at %0t with no request waiting for one", $time);
        end else begin
          if (due_q[0] != cycle) begin
            error_count++;
            $display("response at %0t came %0d cycles off its slot", $time, cycle - due_q[0]);
          end
          compare_val("resp_pd data", 34'(exp_q[0][31:0]), 34'(resp_pd[31:0]));
          compare_val("resp_pd error", 34'(exp_q[0][32]), 34'(resp_pd[32]));
          compare_val("resp_pd kind", 34'(exp_q[0][33]), 34'(resp_pd[33]));
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end else if (exp_q.size() != 0 && due_q[0] <= cycle) begin
        error_count++;
        $display("response missing at %0t, none came in its slot", $time);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
      // consumer group fields and delayed op enable
      if (out_chk) begin
        compare_val("op_en", 34'(exp_op_en), 34'(op_en));
        compare_val("perf_en", 34'(exp_perf_en), 34'(perf_en));
        compare_val("rubik_mode", 34'(exp_mode), 34'(rubik_mode));
        compare_val("in_precision", 34'(exp_prec), 34'(in_precision));
        compare_val("datain_width", 34'(exp_width), 34'(datain_width));
        compare_val("datain_height", 34'(exp_height), 34'(datain_height));
        compare_val("dain_addr_low", 34'(exp_addr_low), 34'(dain_addr_low));
        compare_val("dain_line_stride", 34'(exp_stride), 34'(dain_line_stride));
      end
    end
    pending = exp_q.size();
  end

endmodule

// ==== tb/rbk_clk_gen.sv ====
`timescale 1ns/1ps
module rbk_clk_gen #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 5
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(period_ns / 2) nvdla_core_clk = ~nvdla_core_clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (reset_cycles) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  end

endmodule

// ==== tb/tb_rbk_regfile.sv ====
`timescale 1ns/1ps
module tb_rbk_regfile;
  import rbk_reg_pkg::*;

  localparam int en_delay    = op_en_delay;
  localparam int n_rand      = 200;
  localparam int cycle_limit = 8 * n_rand + 400; // random ops take 3 cycles at most

  logic      nvdla_core_clk;
  logic      nvdla_core_rstn;
  logic      req_pvld;
  req_pd_t   req_pd;
  logic      done;
  logic      resp_valid;
  resp_pd_t  resp_pd;
  logic      op_en;
  logic      perf_en;
  mode_t     rubik_mode;
  prec_t     in_precision;
  dim_t      datain_width;
  dim_t      datain_height;
  addr_low_t dain_addr_low;
  addr_low_t dain_line_stride;

  // expected values handed to the checker
  logic      exp_push;
  resp_pd_t  exp_pd;
  logic      out_chk;
  logic      exp_op_en;
  logic      exp_perf_en;
  mode_t     exp_mode;
  prec_t     exp_prec;
  dim_t      exp_width;
  dim_t      exp_height;
  addr_low_t exp_addr_low;
  addr_low_t exp_stride;
  int        error_count;
  int        check_count;
  int        pending;

  // reference model, word 0 of a group is its op enable
  logic      m_producer;
  logic      m_consumer;
  reg_data_t m_grp [2][6];
  integer    seed = 32'hc6;
  int        cycles = 0;

  rbk_clk_gen u_clk_gen (.nvdla_core_clk, .nvdla_core_rstn);

  rbk_regfile #(.OP_EN_DELAY(en_delay)) uut (
    .nvdla_core_clk, .nvdla_core_rstn, .req_pvld, .req_pd, .done,
    .resp_valid, .resp_pd, .op_en, .perf_en, .rubik_mode, .in_precision,
    .datain_width, .datain_height, .dain_addr_low, .dain_line_stride
  );

  rbk_checker u_checker (
    .nvdla_core_clk, .nvdla_core_rstn, .resp_valid, .resp_pd, .op_en, .perf_en,
    .rubik_mode, .in_precision, .datain_width, .datain_height, .dain_addr_low,
    .dain_line_stride, .exp_push, .exp_pd, .out_chk, .exp_op_en, .exp_perf_en,
    .exp_mode, .exp_prec, .exp_width, .exp_height, .exp_addr_low, .exp_stride,
    .error_count, .check_count, .pending
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////
  function automatic reg_data_t field_mask(input int idx);
    case (idx)
      1:       return 32'h0000_0303;   // mode, precision
      2:       return 32'h1fff_1fff;   // width, height
      3, 4:    return 32'h07ff_ffff;
      default: return 32'h0000_0001;
    endcase
  endfunction

  function automatic logic [1:0] status_of(input logic grp);
    if (!m_grp[grp][0][0]) return 2'd0;          // idle
    return (m_consumer == grp) ? 2'd2 : 2'd1;    // running or pending
  endfunction

  // updates the model for writes, returns expected data for reads
  function automatic reg_data_t ref_access(input logic write, input reg_offset_t off,
                                           input reg_data_t wdata);
    reg_data_t rd;
    int        g;
    int        idx;
    rd = '0;
    g  = int'(m_producer);
    if (off < dual_base) begin
      if (off == offset_pointer) begin
        if (write) m_producer = wdata[0];
        else rd = {15'b0, m_consumer, 15'b0, m_producer};
      end else if (!write) begin
        rd = {14'b0, status_of(1'b1), 14'b0, status_of(1'b0)};
      end
    end else if (off <= offset_perf_enable) begin
      idx = (int'(off) - int'(dual_base)) / 4;
      if (!write) rd = m_grp[g][idx];
      else if (!m_grp[g][0][0]) m_grp[g][idx] = wdata & field_mask(idx); // armed group locked
    end
    return rd;
  endfunction

  function automatic void apply_done();
    m_grp[m_consumer][0] = '0;
    m_consumer = ~m_consumer;
  endfunction

  function automatic req_pd_t make_req(input logic write, input logic nposted,
                                       input logic [21:0] addr, input reg_data_t wdata);
    req_pd_t pd;
    pd        = '0;
    pd[21:0]  = addr;
    pd[53:22] = wdata;
    pd[54]    = write;
    pd[55]    = nposted;
    pd[60:57] = 4'hf;   // byte enables, unused by the unit
    return pd;
  endfunction

  function automatic reg_data_t rand_word();
    return $random(seed);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus, driven on the falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic idle_cycle();
    @(negedge nvdla_core_clk);
    req_pvld = 1'b0;
    done     = 1'b0;
    exp_push = 1'b0;
    out_chk  = 1'b0;
  endtask

  task automatic issue_req(input logic write, input logic nposted, input logic [21:0] addr,
                           input reg_data_t wdata);
    reg_data_t rd;
    rd = ref_access(write, {addr[9:0], 2'b00}, wdata); // upper address bits dropped
    @(negedge nvdla_core_clk);
    req_pvld = 1'b1;
    req_pd   = make_req(write, nposted, addr, wdata);
    done     = 1'b0;
    out_chk  = 1'b0;
    exp_push = !write || nposted;
    exp_pd   = {write, 1'b0, rd};  // kind, error, data
  endtask

  task automatic write_reg(input reg_offset_t off, input reg_data_t data, input logic nposted);
    issue_req(1'b1, nposted, {12'b0, off[11:2]}, data);
  endtask

  task automatic read_reg(input reg_offset_t off);
    issue_req(1'b0, 1'b0, {12'b0, off[11:2]}, '0);
  endtask

  task automatic check_outputs(input logic exp_op);
    int g;
    g = int'(m_consumer);
    @(negedge nvdla_core_clk);
    req_pvld     = 1'b0;
    done         = 1'b0;
    exp_push     = 1'b0;
    out_chk      = 1'b1;
    exp_op_en    = exp_op;
    exp_perf_en  = m_grp[g][5][0];
    exp_mode     = m_grp[g][1][1:0];
    exp_prec     = m_grp[g][1][9:8];
    exp_width    = m_grp[g][2][12:0];
    exp_height   = m_grp[g][2][28:16];
    exp_addr_low = m_grp[g][3][26:0];
    exp_stride   = m_grp[g][4][26:0];
  endtask

  task automatic pulse_done();
    idle_cycle();   // keeps done off the edge where a just written op enable lands
    @(negedge nvdla_core_clk);
    done = 1'b1;
    apply_done();
    check_outputs(1'b0); // delay line flushed at once
  endtask

  task automatic settle_outputs();
    repeat (en_delay + 2) idle_cycle();
    check_outputs(m_grp[m_consumer][0][0]);
  endtask

  task automatic program_group();
    write_reg(offset_misc_cfg, rand_word(), 1'b1);
    write_reg(offset_datain_size, rand_word(), 1'b0);
    write_reg(offset_dain_addr_low, rand_word(), 1'b1);
    write_reg(offset_dain_line_stride, rand_word(), 1'b1);
    write_reg(offset_perf_enable, 32'h1, 1'b0);
  endtask

  always @(posedge nvdla_core_clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the test did not reach its end", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    reg_data_t   wdata;
    req_pvld = 1'b0;
    req_pd   = '0;
    done     = 1'b0;
    exp_push = 1'b0;
    exp_pd   = '0;
    out_chk  = 1'b0;
    exp_op_en    = 1'b0;
    exp_perf_en  = 1'b0;
    exp_mode     = '0;
    exp_prec     = '0;
    exp_width    = '0;
    exp_height   = '0;
    exp_addr_low = '0;
    exp_stride   = '0;
    m_producer = 1'b0;
    m_consumer = 1'b0;
    for (int g = 0; g < 2; g++) begin
      for (int i = 0; i < 6; i++) m_grp[g][i] = '0;
    end
    @(posedge nvdla_core_rstn);
    idle_cycle();

    // reset values
    check_outputs(1'b0);
    read_reg(offset_pointer);
    read_reg(offset_status);
    for (int i = 0; i < 6; i++) read_reg(dual_base + reg_offset_t'(4 * i));

    // producer readback, posted write, unmapped offsets
    write_reg(offset_pointer, 32'h1, 1'b1);
    read_reg(offset_pointer);
    write_reg(offset_pointer, 32'hffff_fffe, 1'b0);
    read_reg(offset_pointer);
    issue_req(1'b0, 1'b0, {12'habc, 10'h000}, '0); // aliases the pointer
    write_reg(12'h020, rand_word(), 1'b1);
    read_reg(12'h020);
    read_reg(12'h03c);
    read_reg(12'hffc);

    // group 0 armed, op_en follows after the delay line
    program_group();
    write_reg(offset_op_enable, 32'h1, 1'b0);
    for (int k = 1; k <= en_delay + 2; k++) check_outputs(k >= en_delay + 2);
    read_reg(offset_status);
    read_reg(offset_op_enable);

    // writes to an armed group are dropped
    write_reg(offset_misc_cfg, rand_word(), 1'b1);
    read_reg(offset_misc_cfg);
    write_reg(offset_op_enable, 32'h0, 1'b1);
    read_reg(offset_op_enable);

    // group 1 through producer 1, then hand over with done
    write_reg(offset_pointer, 32'h1, 1'b1);
    program_group();
    write_reg(offset_op_enable, 32'h1, 1'b1);
    read_reg(offset_status);
    settle_outputs();
    pulse_done();
    read_reg(offset_pointer);
    read_reg(offset_status);
    settle_outputs();

    // random mix over all offsets
    for (int i = 0; i < n_rand; i++) begin
      r     = $random(seed);
      wdata = $random(seed);
      if (r[3:0] == 4'd0) pulse_done();
      else issue_req(r[4], r[5], {r[31:20], 6'b0, r[9:6]}, wdata);
    end
    settle_outputs();

    repeat (4) idle_cycle();
    if (pending != 0) $display("%0d expected responses never arrived", pending);
    $display("checks %0d, errors %0d, missing responses %0d", check_count, error_count, pending);
    if (error_count == 0 && pending == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
design/rbk_reg_pkg.sv
design/rbk_csb_decode.sv
design/rbk_dual_reg.sv
design/rbk_group_ctrl.sv
design/rbk_csb_resp.sv
design/rbk_regfile.sv
tb/rbk_clk_gen.sv
tb/rbk_checker.sv
tb/tb_rbk_regfile.sv
